// ==== jsp_apb_top.f ====
rtl/jsp_pkg.sv
rtl/jsp_toggle_sync.sv
rtl/jsp_level_sync.sv
rtl/jsp_byte_fifo.sv
rtl/jsp_apb_biu.sv
rtl/jsp_apb_top.sv
dv/jsp_tb.sv

// ==== Makefile ====
# Verilator build and run of the JTAG serial port testbench

VERILATOR ?= verilator
TOP       ?= jsp_tb
FILELIST  ?= jsp_apb_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Pass or fail comes from the log, not from the simulator exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/jsp_tb.sv ====
// Testbench for the JTAG serial port bridge, with the APB and JTAG drivers,
// the queue model, the LFSR stimulus and the timeout
`timescale 1ns/1ps
`default_nettype none

module jsp_tb;

  // Upper bound on APB and JTAG transactions over all tests
  localparam int NUM_TXNS       = 200;
  localparam int TIMEOUT_CYCLES = 400 * NUM_TXNS;
  // tck_i cycles for a strobe to reach the FIFO and the counters
  localparam int SETTLE_TCKS    = 12;

  logic               PCLK;
  logic               PRESETn;
  logic               tck_i;
  logic               psel_i;
  logic               penable_i;
  logic               pwrite_i;
  jsp_pkg::reg_addr_t paddr_i;
  jsp_pkg::byte_t     pwdata_i;
  jsp_pkg::byte_t     prdata_o;
  logic               pready_o;
  logic               int_o;
  jsp_pkg::byte_t     data_i;
  logic               wr_strobe_i;
  logic               rd_strobe_i;
  jsp_pkg::byte_t     data_o;
  jsp_pkg::level_t    bytes_available_o;
  jsp_pkg::level_t    bytes_free_o;

  // Model state
  jsp_pkg::byte_t     rx_model [$];
  jsp_pkg::byte_t     tx_model [$];
  logic [3:0]         ier_m;
  jsp_pkg::byte_t     lcr_m;
  jsp_pkg::byte_t     scr_m;
  logic               arm_m;
  int                 errors;
  int                 cycle_cnt;
  logic [31:0]        lfsr_q;

  jsp_apb_top DUT (
    .tck_i             (tck_i),
    .data_i            (data_i),
    .wr_strobe_i       (wr_strobe_i),
    .rd_strobe_i       (rd_strobe_i),
    .data_o            (data_o),
    .bytes_available_o (bytes_available_o),
    .bytes_free_o      (bytes_free_o),
    .PCLK              (PCLK),
    .PRESETn           (PRESETn),
    .psel_i            (psel_i),
    .penable_i         (penable_i),
    .pwrite_i          (pwrite_i),
    .paddr_i           (paddr_i),
    .pwdata_i          (pwdata_i),
    .prdata_o          (prdata_o),
    .pready_o          (pready_o),
    .int_o             (int_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clocks and timeout

  initial begin
    PCLK = 1'b0;
    forever #5 PCLK = ~PCLK;
  end

  initial begin
    tck_i = 1'b0;
    forever #15 tck_i = ~tck_i;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge PCLK);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d PCLK cycles", TIMEOUT_CYCLES);
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers

  // Galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // One LFSR step per bit taken
  function logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[6:0], lfsr_q[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Expected values from the register rules

  function logic exp_int();
    logic rx_ne;
    logic tx_nf;
    rx_ne = (rx_model.size() != 0);
    tx_nf = (tx_model.size() < jsp_pkg::FIFO_DEPTH);
    return (rx_ne & ier_m[0]) | (arm_m & tx_nf & ier_m[1]);
  endfunction

  function jsp_pkg::byte_t exp_read(input jsp_pkg::reg_addr_t addr);
    logic rx_ne;
    logic tx_nf;
    rx_ne = (rx_model.size() != 0);
    tx_nf = (tx_model.size() < jsp_pkg::FIFO_DEPTH);
    case (addr)
      jsp_pkg::ADDR_DATA:    return (lcr_m[7] || !rx_ne) ? 8'h00 : rx_model[0];
      jsp_pkg::ADDR_IER:     return {4'h0, ier_m};
      jsp_pkg::ADDR_IIR_FCR: begin
        // Rx data outranks THR empty
        if (rx_ne) begin
          return jsp_pkg::IIR_RX_DATA;
        end else if (arm_m && tx_nf) begin
          return jsp_pkg::IIR_THR_EMPTY;
        end
        return jsp_pkg::IIR_NONE;
      end
      jsp_pkg::ADDR_LCR:     return lcr_m;
      jsp_pkg::ADDR_MCR:     return 8'h00;
      jsp_pkg::ADDR_LSR:     return {1'b0, tx_nf, tx_nf, 4'h0, rx_ne};
      jsp_pkg::ADDR_MSR:     return jsp_pkg::MSR_VALUE;
      default:               return scr_m;
    endcase
  endfunction

  task automatic check_val(input string what, input logic [7:0] got, input logic [7:0] exp);
    assert (got == exp) else begin
      errors++;
      $display("ERR %0t: %s is %02h, expected %02h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB driver and model update

  // Setup, then access cycles until pready_o
  // Data writes may stall up to 3 access cycles, all else ends in the first
  task automatic apb_xfer(input logic wr, input jsp_pkg::reg_addr_t addr,
                          input jsp_pkg::byte_t wdata, output jsp_pkg::byte_t rdata);
    int acc_cycles;
    int max_cycles;
    max_cycles = (wr && addr == jsp_pkg::ADDR_DATA && !lcr_m[7]) ? 3 : 1;
    @(posedge PCLK);
    #1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge PCLK);
    #1;
    penable_i  = 1'b1;
    acc_cycles = 1;
    @(negedge PCLK);
    while (!pready_o && acc_cycles < max_cycles) begin
      @(negedge PCLK);
      acc_cycles++;
    end
    assert (pready_o) else begin
      errors++;
      $display("ERR %0t: pready_o still low after %0d access cycles", $time, acc_cycles);
      $display("ERRORS FOUND");
      $fatal(1, "late pready_o");
    end
    rdata = prdata_o;
    @(posedge PCLK);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic bus_write(input jsp_pkg::reg_addr_t addr, input jsp_pkg::byte_t d);
    jsp_pkg::byte_t unused;
    apb_xfer(1'b1, addr, d, unused);
    case (addr)
      jsp_pkg::ADDR_DATA: begin
        // Divisor latch hides the data port, a full FIFO drops the byte
        if (!lcr_m[7]) begin
          arm_m = 1'b1;
          if (tx_model.size() < jsp_pkg::FIFO_DEPTH) begin
            tx_model.push_back(d);
          end
        end
      end
      jsp_pkg::ADDR_IER: begin
        if (!lcr_m[7]) begin
          ier_m = d[3:0];
        end
      end
      jsp_pkg::ADDR_IIR_FCR: begin
        if (d[1]) begin
          rx_model.delete();
        end
        if (d[2]) begin
          tx_model.delete();
        end
      end
      jsp_pkg::ADDR_LCR: lcr_m = d;
      jsp_pkg::ADDR_SCR: scr_m = d;
      default: ;
    endcase
  endtask

  task automatic bus_read(input jsp_pkg::reg_addr_t addr);
    jsp_pkg::byte_t exp;
    jsp_pkg::byte_t got;
    exp = exp_read(addr);
    apb_xfer(1'b0, addr, 8'h00, got);
    check_val($sformatf("prdata_o at address %0d", addr), got, exp);
    if (addr == jsp_pkg::ADDR_DATA && !lcr_m[7] && rx_model.size() != 0) begin
      void'(rx_model.pop_front());
    end
    // IIR read disarms THR empty only with no rx data
    if (addr == jsp_pkg::ADDR_IIR_FCR && rx_model.size() == 0) begin
      arm_m = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // JTAG driver

  // Ends just after a tck_i edge so the counters are sampled while stable
  task automatic settle();
    repeat (SETTLE_TCKS) @(posedge tck_i);
    #1;
  endtask

  task automatic jtag_write(input jsp_pkg::byte_t b);
    @(negedge tck_i);
    while (bytes_free_o == '0) @(negedge tck_i);
    @(posedge tck_i);
    #1;
    data_i      = b;
    wr_strobe_i = 1'b1;
    @(posedge tck_i);
    #1;
    wr_strobe_i = 1'b0;
    if (rx_model.size() < jsp_pkg::FIFO_DEPTH) begin
      rx_model.push_back(b);
    end
    settle();
    check_val("bytes_free_o", {4'h0, bytes_free_o}, 8'(jsp_pkg::FIFO_DEPTH - rx_model.size()));
  endtask

  // Host samples data_o, then consumes it with one strobe
  task automatic jtag_read();
    @(negedge tck_i);
    while (bytes_available_o == '0) @(negedge tck_i);
    check_val("data_o", data_o, tx_model[0]);
    @(posedge tck_i);
    #1;
    rd_strobe_i = 1'b1;
    @(posedge tck_i);
    #1;
    rd_strobe_i = 1'b0;
    void'(tx_model.pop_front());
    // Draining to empty arms THR empty
    if (tx_model.size() == 0) begin
      arm_m = 1'b1;
    end
    settle();
    check_val("bytes_available_o", {4'h0, bytes_available_o}, 8'(tx_model.size()));
  endtask

  // int_o before and after an IIR read
  task automatic check_irq();
    @(negedge PCLK);
    check_val("int_o", {7'h0, int_o}, {7'h0, exp_int()});
    bus_read(jsp_pkg::ADDR_IIR_FCR);
    @(negedge PCLK);
    check_val("int_o after IIR read", {7'h0, int_o}, {7'h0, exp_int()});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests

  initial begin
    int n;
    logic [1:0] act;
    errors      = 0;
    lfsr_q      = 32'd74783;
    ier_m       = '0;
    lcr_m       = '0;
    scr_m       = '0;
    arm_m       = 1'b0;
    PRESETn     = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    data_i      = '0;
    wr_strobe_i = 1'b0;
    rd_strobe_i = 1'b0;
    repeat (3) @(posedge PCLK);
    #1;
    PRESETn = 1'b1;
    settle();
    check_val("bytes_free_o after reset", {4'h0, bytes_free_o}, 8'd8);
    check_val("bytes_available_o after reset", {4'h0, bytes_available_o}, 8'd0);

    // JTAG to bus, in order, then an empty read
    n = int'(rand_bits(3)) + 1;
    for (int i = 0; i < n; i++) begin
      jtag_write(rand_bits(8));
      bus_read(jsp_pkg::ADDR_LSR);
    end
    for (int i = 0; i < n; i++) begin
      bus_read(jsp_pkg::ADDR_DATA);
    end
    bus_read(jsp_pkg::ADDR_LSR);
    bus_read(jsp_pkg::ADDR_DATA);

    // Bus to JTAG, one byte per read strobe
    n = int'(rand_bits(3)) + 1;
    for (int i = 0; i < n; i++) begin
      bus_write(jsp_pkg::ADDR_DATA, rand_bits(8));
    end
    settle();
    check_val("bytes_available_o", {4'h0, bytes_available_o}, 8'(tx_model.size()));
    while (tx_model.size() != 0) begin
      jtag_read();
    end

    // Plain registers
    bus_write(jsp_pkg::ADDR_IER, rand_bits(8));
    bus_read(jsp_pkg::ADDR_IER);
    bus_write(jsp_pkg::ADDR_SCR, rand_bits(8));
    bus_read(jsp_pkg::ADDR_SCR);
    bus_write(jsp_pkg::ADDR_LCR, rand_bits(8) & 8'h7F);
    bus_read(jsp_pkg::ADDR_LCR);
    bus_read(jsp_pkg::ADDR_MCR);
    bus_read(jsp_pkg::ADDR_MSR);

    // Divisor latch set: IER and data port frozen
    // Nonzero byte so a hidden data read is told apart from a real one
    jtag_write(rand_bits(8) | 8'h01);
    bus_write(jsp_pkg::ADDR_LCR, rand_bits(8) | 8'h80);
    // Low nibble differs from IER so an accepted write would show
    bus_write(jsp_pkg::ADDR_IER, (rand_bits(8) & 8'hF0) | {4'h0, ~ier_m});
    bus_read(jsp_pkg::ADDR_IER);
    bus_read(jsp_pkg::ADDR_DATA);
    bus_write(jsp_pkg::ADDR_DATA, rand_bits(8));
    settle();
    check_val("bytes_available_o with DLAB", {4'h0, bytes_available_o}, 8'(tx_model.size()));
    bus_read(jsp_pkg::ADDR_LSR);
    bus_read(jsp_pkg::ADDR_LCR);
    bus_write(jsp_pkg::ADDR_LCR, rand_bits(8) & 8'h7F);
    bus_read(jsp_pkg::ADDR_DATA);

    // FCR clears, rx first, then tx
    for (int i = 0; i < 3; i++) begin
      jtag_write(rand_bits(8));
      bus_write(jsp_pkg::ADDR_DATA, rand_bits(8));
    end
    settle();
    bus_read(jsp_pkg::ADDR_LSR);
    bus_write(jsp_pkg::ADDR_IIR_FCR, (rand_bits(8) & 8'hF9) | 8'h02);
    bus_read(jsp_pkg::ADDR_LSR);
    settle();
    check_val("bytes_free_o after rx clear", {4'h0, bytes_free_o}, 8'd8);
    check_val("bytes_available_o", {4'h0, bytes_available_o}, 8'(tx_model.size()));
    bus_write(jsp_pkg::ADDR_IIR_FCR, (rand_bits(8) & 8'hF9) | 8'h04);
    settle();
    check_val("bytes_available_o after tx clear", {4'h0, bytes_available_o}, 8'd0);
    bus_read(jsp_pkg::ADDR_LSR);
    for (int i = 0; i < 2; i++) begin
      jtag_write(rand_bits(8));
      bus_write(jsp_pkg::ADDR_DATA, rand_bits(8));
    end
    for (int i = 0; i < 2; i++) begin
      bus_read(jsp_pkg::ADDR_DATA);
      jtag_read();
    end

    // IIR and int_o over random IER values and traffic
    for (int i = 0; i < 6; i++) begin
      bus_write(jsp_pkg::ADDR_IER, rand_bits(8));
      check_irq();
      for (int j = 0; j < 4; j++) begin
        act = 2'(rand_bits(2));
        case (act)
          2'd0: begin
            if (rx_model.size() < 4) begin
              jtag_write(rand_bits(8));
            end
          end
          2'd1: bus_read(jsp_pkg::ADDR_DATA);
          2'd2: begin
            if (tx_model.size() < 6) begin
              bus_write(jsp_pkg::ADDR_DATA, rand_bits(8));
            end
          end
          default: begin
            if (tx_model.size() != 0) begin
              jtag_read();
            end
          end
        endcase
        check_irq();
      end
    end

    // Arm flag set by a write, cleared by IIR read, set again by drain
    while (rx_model.size() != 0) begin
      bus_read(jsp_pkg::ADDR_DATA);
    end
    while (tx_model.size() != 0) begin
      jtag_read();
    end
    bus_write(jsp_pkg::ADDR_IER, 8'h02);
    bus_write(jsp_pkg::ADDR_DATA, rand_bits(8));
    check_irq();
    check_irq();
    jtag_read();
    check_irq();

    // Overfill the tx FIFO, only the first 8 survive
    for (int i = 0; i < 10; i++) begin
      bus_write(jsp_pkg::ADDR_DATA, rand_bits(8));
      bus_read(jsp_pkg::ADDR_LSR);
    end
    settle();
    check_val("bytes_available_o when full", {4'h0, bytes_available_o}, 8'd8);
    check_irq();
    while (tx_model.size() != 0) begin
      jtag_read();
    end

    if (errors == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

// ==== rtl/jsp_apb_top.sv ====
// Top level of the JTAG serial port, tck_i strobe logic plus the
// synchronisers, both byte FIFOs and the APB interface
`timescale 1ns/1ps
`default_nettype none

module jsp_apb_top (
  // JTAG side
  input  wire                     tck_i,
  input  wire jsp_pkg::byte_t     data_i,
  input  wire                     wr_strobe_i,
  input  wire                     rd_strobe_i,
  output jsp_pkg::byte_t          data_o,
  output jsp_pkg::level_t         bytes_available_o,
  output jsp_pkg::level_t         bytes_free_o,
  // APB side
  input  wire                     PCLK,
  input  wire                     PRESETn,
  input  wire                     psel_i,
  input  wire                     penable_i,
  input  wire                     pwrite_i,
  input  wire jsp_pkg::reg_addr_t paddr_i,
  input  wire jsp_pkg::byte_t     pwdata_i,
  output jsp_pkg::byte_t          prdata_o,
  output logic                    pready_o,
  output logic                    int_o
);

  jsp_pkg::byte_t  jtag_wdata_q;
  logic            wr_tgl_q;
  logic            rd_tgl_q;
  logic            wr_pending;
  logic            rd_pending;
  logic            wr_clear;
  logic            rd_clear;
  // JTAG-to-APB FIFO
  logic            rx_en;
  logic            rx_push;
  logic            rx_clear;
  jsp_pkg::byte_t  rx_head;
  jsp_pkg::level_t rx_level;
  jsp_pkg::level_t rx_free;
  // APB-to-JTAG FIFO
  logic            tx_en;
  logic            tx_push;
  logic            tx_clear;
  jsp_pkg::byte_t  tx_data;
  jsp_pkg::byte_t  tx_head;
  jsp_pkg::level_t tx_level;

  ////////////////////////////////////////////////////////////////////////////
  // tck_i domain

  // Each strobe flips its toggle once
  always_ff @(posedge tck_i or negedge PRESETn) begin
    if (!PRESETn) begin
      wr_tgl_q <= 1'b0;
      rd_tgl_q <= 1'b0;
    end else begin
      wr_tgl_q <= wr_tgl_q ^ wr_strobe_i;
      rd_tgl_q <= rd_tgl_q ^ rd_strobe_i;
    end
  end

  // Byte is stable long before PCLK acts on the pending flag
  always_ff @(posedge tck_i) begin
    if (wr_strobe_i) begin
      jtag_wdata_q <= data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Crossings

  jsp_toggle_sync u_wr_sync (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .toggle_i  (wr_tgl_q),
    .clear_i   (wr_clear),
    .pending_o (wr_pending)
  );

  jsp_toggle_sync u_rd_sync (
    .PCLK      (PCLK),
    .PRESETn   (PRESETn),
    .toggle_i  (rd_tgl_q),
    .clear_i   (rd_clear),
    .pending_o (rd_pending)
  );

  // Space the host may write into
  jsp_level_sync u_free_sync (
    .PCLK    (PCLK),
    .tck_i   (tck_i),
    .PRESETn (PRESETn),
    .level_i (rx_free),
    .level_o (bytes_free_o)
  );

  // Bytes waiting for the host
  jsp_level_sync u_avail_sync (
    .PCLK    (PCLK),
    .tck_i   (tck_i),
    .PRESETn (PRESETn),
    .level_i (tx_level),
    .level_o (bytes_available_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // FIFOs and bus interface

  jsp_byte_fifo u_rx_fifo (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .clear_i (rx_clear),
    .en_i    (rx_en),
    .push_i  (rx_push),
    .data_i  (jtag_wdata_q),
    .data_o  (rx_head),
    .level_o (rx_level),
    .free_o  (rx_free)
  );

  jsp_byte_fifo u_tx_fifo (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .clear_i (tx_clear),
    .en_i    (tx_en),
    .push_i  (tx_push),
    .data_i  (tx_data),
    .data_o  (tx_head),
    .level_o (tx_level),
    .free_o  ()
  );

  jsp_apb_biu u_biu (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .wr_pending_i (wr_pending),
    .rd_pending_i (rd_pending),
    .rx_head_i    (rx_head),
    .rx_level_i   (rx_level),
    .tx_head_i    (tx_head),
    .tx_level_i   (tx_level),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .wr_clear_o   (wr_clear),
    .rd_clear_o   (rd_clear),
    .rx_en_o      (rx_en),
    .rx_push_o    (rx_push),
    .rx_clear_o   (rx_clear),
    .tx_en_o      (tx_en),
    .tx_push_o    (tx_push),
    .tx_clear_o   (tx_clear),
    .tx_data_o    (tx_data),
    .head_o       (data_o),
    .int_o        (int_o)
  );

endmodule

`default_nettype wire

// ==== rtl/jsp_apb_biu.sv ====
// APB register decode, rx/tx FIFO control FSMs, interrupt and
// read data mux of the JTAG serial port
`timescale 1ns/1ps
`default_nettype none

module jsp_apb_biu (
  input  wire                    PCLK,
  input  wire                    PRESETn,
  input  wire                    psel_i,
  input  wire                    penable_i,
  input  wire                    pwrite_i,
  input  wire jsp_pkg::reg_addr_t paddr_i,
  input  wire jsp_pkg::byte_t    pwdata_i,
  input  wire                    wr_pending_i,
  input  wire                    rd_pending_i,
  input  wire jsp_pkg::byte_t    rx_head_i,
  input  wire jsp_pkg::level_t   rx_level_i,
  input  wire jsp_pkg::byte_t    tx_head_i,
  input  wire jsp_pkg::level_t   tx_level_i,
  output jsp_pkg::byte_t         prdata_o,
  output logic                   pready_o,
  output logic                   wr_clear_o,
  output logic                   rd_clear_o,
  output logic                   rx_en_o,
  output logic                   rx_push_o,
  output logic                   rx_clear_o,
  output logic                   tx_en_o,
  output logic                   tx_push_o,
  output logic                   tx_clear_o,
  output jsp_pkg::byte_t         tx_data_o,
  output jsp_pkg::byte_t         head_o,
  output logic                   int_o
);

  // Software visible registers
  logic [3:0]         ier_q;
  jsp_pkg::byte_t     lcr_q;
  jsp_pkg::byte_t     scr_q;
  logic               thr_arm_q;
  // Bus handshake
  logic               reg_ack_q;
  logic               wr_req_q;
  logic               setup;
  logic               access;
  logic               dlab;
  logic               data_sel;
  logic               bus_rd_data;
  logic               bus_wr_data;
  logic               wr_req;
  // Status
  logic               rx_not_empty;
  logic               tx_not_full;
  logic               tx_draining;
  logic               iir_read;
  jsp_pkg::byte_t     iir;
  jsp_pkg::byte_t     lsr;
  jsp_pkg::rx_state_e rx_state_q;
  jsp_pkg::rx_state_e rx_state_d;
  jsp_pkg::tx_state_e tx_state_q;
  jsp_pkg::tx_state_e tx_state_d;

  ////////////////////////////////////////////////////////////////////////////
  // APB decode

  assign setup  = psel_i & ~penable_i;
  assign access = psel_i & penable_i;
  assign dlab   = lcr_q[7];

  // Divisor latch access hides the data port
  assign data_sel    = (paddr_i == jsp_pkg::ADDR_DATA) & ~dlab;
  assign bus_rd_data = setup & ~pwrite_i & data_sel;
  assign bus_wr_data = setup & pwrite_i & data_sel;
  // Write request seen in setup or still waiting for the tx FSM
  assign wr_req      = wr_req_q | bus_wr_data;

  // Everything but a data write completes in the first access cycle
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      reg_ack_q <= 1'b0;
      wr_req_q  <= 1'b0;
    end else begin
      reg_ack_q <= setup & ~(pwrite_i & data_sel);
      if (tx_state_q == jsp_pkg::TX_PUSH) begin
        wr_req_q <= 1'b0;
      end else if (bus_wr_data) begin
        wr_req_q <= 1'b1;
      end
    end
  end

  // Data writes end in the PUSH cycle, full or not
  assign pready_o = reg_ack_q | (tx_state_q == jsp_pkg::TX_PUSH);

  // FCR flush bits act in the access cycle
  assign rx_clear_o = access & pwrite_i & (paddr_i == jsp_pkg::ADDR_IIR_FCR) & pwdata_i[1];
  assign tx_clear_o = access & pwrite_i & (paddr_i == jsp_pkg::ADDR_IIR_FCR) & pwdata_i[2];

  // IER, LCR and SCR
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      ier_q <= '0;
      lcr_q <= '0;
      scr_q <= '0;
    end else if (access && pwrite_i) begin
      case (paddr_i)
        jsp_pkg::ADDR_IER: begin
          if (!dlab) begin
            ier_q <= pwdata_i[3:0];
          end
        end
        jsp_pkg::ADDR_LCR: lcr_q <= pwdata_i;
        jsp_pkg::ADDR_SCR: scr_q <= pwdata_i;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Rx FSM, JTAG bytes in and bus reads out; bus read wins

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      rx_state_q <= jsp_pkg::RX_IDLE;
    end else begin
      rx_state_q <= rx_state_d;
    end
  end

  always_comb begin
    rx_state_d = jsp_pkg::RX_IDLE;
    if (bus_rd_data) begin
      // Pop lands on the access cycle
      rx_state_d = jsp_pkg::RX_POP;
    end else if (wr_pending_i && rx_state_q != jsp_pkg::RX_PUSH) begin
      // Pending flag still set during PUSH, so no second push
      rx_state_d = jsp_pkg::RX_PUSH;
    end
  end

  assign rx_en_o    = (rx_state_q != jsp_pkg::RX_IDLE);
  assign rx_push_o  = (rx_state_q == jsp_pkg::RX_PUSH);
  assign wr_clear_o = (rx_state_q == jsp_pkg::RX_PUSH);

  ////////////////////////////////////////////////////////////////////////////
  // Tx FSM, bus writes in and JTAG reads out

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      tx_state_q <= jsp_pkg::TX_IDLE;
    end else begin
      tx_state_q <= tx_state_d;
    end
  end

  always_comb begin
    tx_state_d = jsp_pkg::TX_IDLE;
    case (tx_state_q)
      jsp_pkg::TX_IDLE: begin
        if (rd_pending_i) begin
          tx_state_d = jsp_pkg::TX_POP;
        end else if (wr_req) begin
          tx_state_d = jsp_pkg::TX_PUSH;
        end
      end
      jsp_pkg::TX_PUSH: begin
        // First byte into an empty FIFO must reach head_o
        if (tx_level_i == '0) begin
          tx_state_d = jsp_pkg::TX_LATCH;
        end else if (rd_pending_i) begin
          tx_state_d = jsp_pkg::TX_POP;
        end
      end
      jsp_pkg::TX_POP: tx_state_d = jsp_pkg::TX_LATCH;
      jsp_pkg::TX_LATCH: begin
        if (wr_req) begin
          tx_state_d = jsp_pkg::TX_PUSH;
        end else if (rd_pending_i) begin
          tx_state_d = jsp_pkg::TX_POP;
        end
      end
      default: tx_state_d = jsp_pkg::TX_IDLE;
    endcase
  end

  assign tx_en_o    = (tx_state_q == jsp_pkg::TX_PUSH) | (tx_state_q == jsp_pkg::TX_POP);
  assign tx_push_o  = (tx_state_q == jsp_pkg::TX_PUSH);
  assign rd_clear_o = (tx_state_q == jsp_pkg::TX_POP);
  // PWDATA is held for the whole access
  assign tx_data_o  = pwdata_i;

  // Byte presented to the JTAG host
  always_ff @(posedge PCLK) begin
    if (tx_state_q == jsp_pkg::TX_LATCH) begin
      head_o <= tx_head_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Status, IIR and interrupt

  assign rx_not_empty = (rx_level_i != '0);
  assign tx_not_full  = (tx_level_i != jsp_pkg::level_t'(jsp_pkg::FIFO_DEPTH));
  // Last byte leaving the tx FIFO
  assign tx_draining  = tx_en_o & ~tx_push_o & (tx_level_i == 4'd1);
  assign iir_read     = access & ~pwrite_i & (paddr_i == jsp_pkg::ADDR_IIR_FCR);

  // THR empty arm flag
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      thr_arm_q <= 1'b0;
    end else if (bus_wr_data || tx_draining) begin
      thr_arm_q <= 1'b1;
    end else if (iir_read && !rx_not_empty) begin
      thr_arm_q <= 1'b0;
    end
  end

  always_comb begin
    if (rx_not_empty) begin
      iir = jsp_pkg::IIR_RX_DATA;
    end else if (thr_arm_q && tx_not_full) begin
      iir = jsp_pkg::IIR_THR_EMPTY;
    end else begin
      iir = jsp_pkg::IIR_NONE;
    end
  end

  // THRE and TEMT both follow tx space, DR follows rx data
  assign lsr = {1'b0, tx_not_full, tx_not_full, 4'h0, rx_not_empty};

  assign int_o = (rx_not_empty & ier_q[0]) | (thr_arm_q & tx_not_full & ier_q[1]);

  // Read data mux
  always_comb begin
    case (paddr_i)
      jsp_pkg::ADDR_DATA:    prdata_o = (dlab || !rx_not_empty) ? '0 : rx_head_i;
      jsp_pkg::ADDR_IER:     prdata_o = {4'h0, ier_q};
      jsp_pkg::ADDR_IIR_FCR: prdata_o = iir;
      jsp_pkg::ADDR_LCR:     prdata_o = lcr_q;
      jsp_pkg::ADDR_MCR:     prdata_o = '0;
      jsp_pkg::ADDR_LSR:     prdata_o = lsr;
      jsp_pkg::ADDR_MSR:     prdata_o = jsp_pkg::MSR_VALUE;
      default:               prdata_o = scr_q;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/jsp_byte_fifo.sv ====
// Byte FIFO with one push or pop per cycle, level and free counts
`timescale 1ns/1ps
`default_nettype none

module jsp_byte_fifo (
  input  wire                  PCLK,
  input  wire                  PRESETn,
  input  wire                  clear_i,
  input  wire                  en_i,
  input  wire                  push_i,
  input  wire jsp_pkg::byte_t  data_i,
  output jsp_pkg::byte_t       data_o,
  output jsp_pkg::level_t      level_o,
  output jsp_pkg::level_t      free_o
);

  // Circular storage, pointers wrap naturally at the power-of-two depth
  jsp_pkg::byte_t mem_q [jsp_pkg::FIFO_DEPTH];
  logic [$clog2(jsp_pkg::FIFO_DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(jsp_pkg::FIFO_DEPTH)-1:0] wr_ptr_q;
  jsp_pkg::level_t level_q;
  logic            full;
  logic            empty;
  logic            do_push;
  logic            do_pop;

  assign full  = (level_q == jsp_pkg::level_t'(jsp_pkg::FIFO_DEPTH));
  assign empty = (level_q == '0);

  // push_i selects the direction, overflow and underflow are dropped
  assign do_push = en_i & push_i & ~full;
  assign do_pop  = en_i & ~push_i & ~empty;

  // Pointers and count
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      level_q  <= '0;
    end else if (clear_i) begin
      // Synchronous flush from FCR
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      level_q  <= '0;
    end else if (do_push) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
      level_q  <= level_q + 1'b1;
    end else if (do_pop) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
      level_q  <= level_q - 1'b1;
    end
  end

  // Storage write
  always_ff @(posedge PCLK) begin
    if (do_push && !clear_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Head is always visible
  assign data_o  = mem_q[rd_ptr_q];
  assign level_o = level_q;
  assign free_o  = jsp_pkg::level_t'(jsp_pkg::FIFO_DEPTH) - level_q;

endmodule

`default_nettype wire

// ==== rtl/jsp_level_sync.sv ====
// Request/acknowledge word synchroniser for a FIFO level, PCLK to tck_i
`timescale 1ns/1ps
`default_nettype none

module jsp_level_sync (
  input  wire                  PCLK,
  input  wire                  tck_i,
  input  wire                  PRESETn,
  input  wire jsp_pkg::level_t level_i,
  output jsp_pkg::level_t      level_o
);

  // PCLK side state
  jsp_pkg::level_t hold_q;
  logic            req_q;
  logic [1:0]      ack_sync_q;
  logic            src_idle;
  // tck_i side state
  logic [1:0]      req_sync_q;
  logic            ack_q;

  ////////////////////////////////////////////////////////////////////////////
  // PCLK side

  // Previous handshake done once the returned ack matches req
  assign src_idle = (ack_sync_q[1] == req_q);

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      req_q      <= 1'b0;
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[0], ack_q};
      if (src_idle) begin
        req_q <= ~req_q;
      end
    end
  end

  // Held word stays frozen until tck_i has taken it
  always_ff @(posedge PCLK) begin
    if (src_idle) begin
      hold_q <= level_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tck_i side

  always_ff @(posedge tck_i or negedge PRESETn) begin
    if (!PRESETn) begin
      req_sync_q <= '0;
      ack_q      <= 1'b0;
      level_o    <= '0;
    end else begin
      req_sync_q <= {req_sync_q[0], req_q};
      // New request seen, hold_q is stable here
      if (req_sync_q[1] != ack_q) begin
        level_o <= hold_q;
        ack_q   <= req_sync_q[1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/jsp_toggle_sync.sv ====
// Toggle-to-pending synchroniser, carries a tck_i strobe into PCLK
`timescale 1ns/1ps
`default_nettype none

module jsp_toggle_sync (
  input  wire  PCLK,
  input  wire  PRESETn,
  input  wire  toggle_i,
  input  wire  clear_i,
  output logic pending_o
);

  // Two synchroniser flops plus one history flop for edge detection
  logic [2:0] sync_q;
  logic       toggle_edge;

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[1:0], toggle_i};
    end
  end

  // Either polarity of change marks one strobe
  assign toggle_edge = sync_q[2] ^ sync_q[1];

  // Sticky flag, a new edge wins over a clear in the same cycle
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      pending_o <= 1'b0;
    end else if (toggle_edge) begin
      pending_o <= 1'b1;
    end else if (clear_i) begin
      pending_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/jsp_pkg.sv ====
// Shared types, APB register map, IIR codes and FSM encodings
// for the JTAG serial port bridge
`default_nettype none

package jsp_pkg;

  // Data byte moved through either FIFO
  typedef logic [7:0] byte_t;

  // FIFO occupancy or free count, range 0 to 8
  typedef logic [3:0] level_t;

  // APB word index into the 16550-style register map
  typedef logic [2:0] reg_addr_t;

  // Both FIFOs have the same depth
  localparam int FIFO_DEPTH = 8;

  // Register map, DATA shares its slot with THR/RBR
  localparam reg_addr_t ADDR_DATA    = 3'd0;
  localparam reg_addr_t ADDR_IER     = 3'd1;
  localparam reg_addr_t ADDR_IIR_FCR = 3'd2;
  localparam reg_addr_t ADDR_LCR     = 3'd3;
  localparam reg_addr_t ADDR_MCR     = 3'd4;
  localparam reg_addr_t ADDR_LSR     = 3'd5;
  localparam reg_addr_t ADDR_MSR     = 3'd6;
  localparam reg_addr_t ADDR_SCR     = 3'd7;

  // IIR codes, highest priority first
  localparam byte_t IIR_RX_DATA   = 8'h04;
  localparam byte_t IIR_THR_EMPTY = 8'h02;
  localparam byte_t IIR_NONE      = 8'h01;

  // Fixed modem status seen by software
  localparam byte_t MSR_VALUE = 8'h0B;

  // JTAG-to-APB FIFO machine
  typedef enum logic [1:0] {RX_IDLE, RX_PUSH, RX_POP} rx_state_e;

  // APB-to-JTAG FIFO machine
  typedef enum logic [1:0] {TX_IDLE, TX_PUSH, TX_POP, TX_LATCH} tx_state_e;

endpackage

`default_nettype wire
